// ==== xbar_pkg.sv ====
package xbar_pkg;

  // Crossbar geometry
  localparam int unsigned NO_SLV   = 2;
  localparam int unsigned NO_MST   = 2;
  localparam int unsigned NO_RULES = 3;

  // ID handling: only the low ID_USED bits are tracked for ordering
  localparam int unsigned ID_W      = 4;
  localparam int unsigned ID_USED   = 2;
  localparam int unsigned MAX_TRANS = 3;
  // Counter must be able to hold MAX_TRANS itself
  localparam int unsigned CNT_W     = $clog2(MAX_TRANS + 1);

  typedef logic [31:0]     addr_t;
  typedef logic [31:0]     data_t;
  typedef logic [1:0]      resp_t;
  typedef logic [ID_W-1:0] slv_id_t;
  // Slave index sits on top of the master-side ID
  typedef logic [ID_W:0]   mst_id_t;
  typedef logic [0:0]      mst_idx_t;
  // Value NO_MST selects the decode-error responder
  typedef logic [1:0]      sel_t;
  typedef logic [0:0]      slv_idx_t;

  localparam resp_t RESP_OKAY   = 2'd0;
  localparam resp_t RESP_DECERR = 2'd3;
  localparam data_t DECERR_DATA = 32'hDEC0_DEAD;

  // Address window, start included and end excluded
  typedef struct packed {
    mst_idx_t mst_idx;
    addr_t    start_addr;
    addr_t    end_addr;
  } rule_t;

  typedef struct packed {
    slv_id_t id;
    addr_t   addr;
  } ar_slv_t;

  typedef struct packed {
    mst_id_t id;
    addr_t   addr;
  } ar_mst_t;

  typedef struct packed {
    slv_id_t id;
    data_t   data;
    resp_t   resp;
  } r_slv_t;

  typedef struct packed {
    mst_id_t id;
    data_t   data;
    resp_t   resp;
  } r_mst_t;

endpackage

// ==== addr_decode.sv ====
`timescale 1ns/1ns

module addr_decode (
  input  xbar_pkg::addr_t                        addr_i,
  input  xbar_pkg::rule_t [xbar_pkg::NO_RULES-1:0] addr_map_i,
  input  logic                                   en_default_i,
  input  xbar_pkg::mst_idx_t                     default_port_i,
  output xbar_pkg::sel_t                         sel_o
);

  import xbar_pkg::*;

  logic hit;

  always_comb begin
    hit   = 1'b0;
    sel_o = sel_t'(NO_MST);
    // Walk every rule, a later match overrides an earlier one
    for (int unsigned r = 0; r < NO_RULES; r++) begin
      if ((addr_i >= addr_map_i[r].start_addr) && (addr_i < addr_map_i[r].end_addr)) begin
        hit   = 1'b1;
        sel_o = sel_t'(addr_map_i[r].mst_idx);
      end
    end
    // Nothing covered the address
    if (!hit) begin
      if (en_default_i) begin
        sel_o = sel_t'(default_port_i);
      end else begin
        // Route to the local decode-error responder
        sel_o = sel_t'(NO_MST);
      end
    end
  end

endmodule

// ==== rr_arbiter.sv ====
`timescale 1ns/1ns

module rr_arbiter #(
  parameter int unsigned N = 2,
  parameter type payload_t = logic
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic     [N-1:0]     req_valid_i,
  input  payload_t [N-1:0]     req_data_i,
  output logic     [N-1:0]     req_ready_o,
  output logic                 out_valid_o,
  output payload_t             out_data_o,
  input  logic                 out_ready_i,
  output logic [$clog2(N)-1:0] grant_o
);

  // Next requester to get first pick
  logic [$clog2(N)-1:0] prio_q;
  // Grant held while the output is stalled
  logic [$clog2(N)-1:0] lock_idx_q;
  logic                 lock_q;
  logic [$clog2(N)-1:0] pick;

  // Search from the priority pointer upward, wrapping at N
  always_comb begin
    int unsigned idx;
    logic        found;
    idx   = 0;
    found = 1'b0;
    pick  = prio_q;
    for (int unsigned i = 0; i < N; i++) begin
      idx = prio_q + i;
      if (idx >= N) begin
        idx = idx - N;
      end
      if (!found && req_valid_i[idx]) begin
        found = 1'b1;
        pick  = idx[$clog2(N)-1:0];
      end
    end
  end

  assign grant_o     = lock_q ? lock_idx_q : pick;
  // Requesters hold valid, so a locked grant stays valid
  assign out_valid_o = req_valid_i[grant_o];
  assign out_data_o  = req_data_i[grant_o];

  always_comb begin
    req_ready_o          = '0;
    req_ready_o[grant_o] = out_ready_i & out_valid_o;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      prio_q     <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (out_valid_o && out_ready_i) begin
      // Served requester goes to the back of the line
      lock_q <= 1'b0;
      prio_q <= (grant_o == N - 1) ? '0 : grant_o + 1'b1;
    end else begin
      lock_q     <= out_valid_o;
      lock_idx_q <= grant_o;
    end
  end

endmodule

// ==== read_demux.sv ====
`timescale 1ns/1ns

module read_demux (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  // Slave-side AR
  input  logic                                      slv_ar_valid_i,
  input  xbar_pkg::ar_slv_t                         slv_ar_i,
  output logic                                      slv_ar_ready_o,
  input  xbar_pkg::sel_t                            sel_i,
  // Slave-side R
  output logic                                      slv_r_valid_o,
  output xbar_pkg::r_slv_t                          slv_r_o,
  input  logic                                      slv_r_ready_i,
  // One AR lane per master port plus the decode-error responder
  output logic              [xbar_pkg::NO_MST:0]    dst_ar_valid_o,
  output xbar_pkg::ar_slv_t                         dst_ar_o,
  input  logic              [xbar_pkg::NO_MST:0]    dst_ar_ready_i,
  // Returning R beats from the same destinations
  input  logic              [xbar_pkg::NO_MST:0]    dst_r_valid_i,
  input  xbar_pkg::r_slv_t  [xbar_pkg::NO_MST:0]    dst_r_i,
  output logic              [xbar_pkg::NO_MST:0]    dst_r_ready_o
);

  import xbar_pkg::*;

  // Ordering table, one slot per value of the used ID bits
  logic [CNT_W-1:0] cnt_q [2**ID_USED];
  sel_t             dst_q [2**ID_USED];

  logic [ID_USED-1:0]    ar_idx;
  logic [ID_USED-1:0]    r_idx;
  logic [2**ID_USED-1:0] inc;
  logic [2**ID_USED-1:0] dec;
  logic                  stall;
  logic                  ar_hs;
  logic                  r_hs;

  assign ar_idx = slv_ar_i.id[ID_USED-1:0];

  // Same ID in flight elsewhere, or this ID has no counter room left
  assign stall = (cnt_q[ar_idx] == CNT_W'(MAX_TRANS)) ||
                 ((cnt_q[ar_idx] != '0) && (dst_q[ar_idx] != sel_i));

  always_comb begin
    dst_ar_valid_o        = '0;
    dst_ar_valid_o[sel_i] = slv_ar_valid_i & ~stall;
  end

  // Payload is shared, only the valid is steered
  assign dst_ar_o       = slv_ar_i;
  assign slv_ar_ready_o = ~stall & dst_ar_ready_i[sel_i];
  assign ar_hs          = slv_ar_valid_i & slv_ar_ready_o;

  // R beats from all destinations compete for the single slave R port
  rr_arbiter #(
    .N         ( NO_MST + 1 ),
    .payload_t ( r_slv_t    )
  ) u_r_arb (
    .clk_i       ( clk_i         ),
    .rst_n_i     ( rst_n_i       ),
    .req_valid_i ( dst_r_valid_i ),
    .req_data_i  ( dst_r_i       ),
    .req_ready_o ( dst_r_ready_o ),
    .out_valid_o ( slv_r_valid_o ),
    .out_data_o  ( slv_r_o       ),
    .out_ready_i ( slv_r_ready_i ),
    .grant_o     (               )
  );

  assign r_hs  = slv_r_valid_o & slv_r_ready_i;
  assign r_idx = slv_r_o.id[ID_USED-1:0];

  always_comb begin
    inc         = '0;
    dec         = '0;
    inc[ar_idx] = ar_hs;
    dec[r_idx]  = r_hs;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int unsigned i = 0; i < 2**ID_USED; i++) begin
        cnt_q[i] <= '0;
        dst_q[i] <= '0;
      end
    end else begin
      for (int unsigned i = 0; i < 2**ID_USED; i++) begin
        // Accept and delivery of the same ID in one cycle cancel out
        case ({inc[i], dec[i]})
          2'b10:   cnt_q[i] <= cnt_q[i] + 1'b1;
          2'b01:   cnt_q[i] <= cnt_q[i] - 1'b1;
          default: cnt_q[i] <= cnt_q[i];
        endcase
        if (inc[i]) begin
          dst_q[i] <= sel_i;
        end
      end
    end
  end

endmodule

// ==== decerr_responder.sv ====
`timescale 1ns/1ns

module decerr_responder (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              ar_valid_i,
  input  xbar_pkg::ar_slv_t ar_i,
  output logic              ar_ready_o,
  output logic              r_valid_o,
  output xbar_pkg::r_slv_t  r_o,
  input  logic              r_ready_i
);

  import xbar_pkg::*;

  logic    r_valid_q;
  slv_id_t id_q;

  // One read at a time, blocked while the error beat waits
  assign ar_ready_o = ~r_valid_q;
  assign r_valid_o  = r_valid_q;

  assign r_o.id   = id_q;
  assign r_o.data = DECERR_DATA;
  assign r_o.resp = RESP_DECERR;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      r_valid_q <= 1'b0;
    end else if (ar_valid_i && ar_ready_o) begin
      r_valid_q <= 1'b1;
    end else if (r_valid_q && r_ready_i) begin
      r_valid_q <= 1'b0;
    end
  end

  // Only the ID is needed to answer
  always_ff @(posedge clk_i) begin
    if (ar_valid_i && ar_ready_o) begin
      id_q <= ar_i.id;
    end
  end

endmodule

// ==== read_mux.sv ====
`timescale 1ns/1ns

module read_mux (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  // From the slave-port demuxes
  input  logic              [xbar_pkg::NO_SLV-1:0]  slv_ar_valid_i,
  input  xbar_pkg::ar_slv_t [xbar_pkg::NO_SLV-1:0]  slv_ar_i,
  output logic              [xbar_pkg::NO_SLV-1:0]  slv_ar_ready_o,
  output logic              [xbar_pkg::NO_SLV-1:0]  slv_r_valid_o,
  output xbar_pkg::r_slv_t                          slv_r_o,
  input  logic              [xbar_pkg::NO_SLV-1:0]  slv_r_ready_i,
  // Master port
  output logic                                      mst_ar_valid_o,
  output xbar_pkg::ar_mst_t                         mst_ar_o,
  input  logic                                      mst_ar_ready_i,
  input  logic                                      mst_r_valid_i,
  input  xbar_pkg::r_mst_t                          mst_r_i,
  output logic                                      mst_r_ready_o
);

  import xbar_pkg::*;

  ar_mst_t [NO_SLV-1:0] ar_wide;
  slv_idx_t             r_dst;

  // Prepend the slave index so the response can find its way back
  always_comb begin
    for (int unsigned i = 0; i < NO_SLV; i++) begin
      ar_wide[i].id   = {slv_idx_t'(i), slv_ar_i[i].id};
      ar_wide[i].addr = slv_ar_i[i].addr;
    end
  end

  rr_arbiter #(
    .N         ( NO_SLV   ),
    .payload_t ( ar_mst_t )
  ) u_ar_arb (
    .clk_i       ( clk_i          ),
    .rst_n_i     ( rst_n_i        ),
    .req_valid_i ( slv_ar_valid_i ),
    .req_data_i  ( ar_wide        ),
    .req_ready_o ( slv_ar_ready_o ),
    .out_valid_o ( mst_ar_valid_o ),
    .out_data_o  ( mst_ar_o       ),
    .out_ready_i ( mst_ar_ready_i ),
    .grant_o     (                )
  );

  // Top ID bit names the slave port, strip it on the way back
  assign r_dst        = mst_r_i.id[ID_W];
  assign slv_r_o.id   = mst_r_i.id[ID_W-1:0];
  assign slv_r_o.data = mst_r_i.data;
  assign slv_r_o.resp = mst_r_i.resp;

  always_comb begin
    slv_r_valid_o        = '0;
    slv_r_valid_o[r_dst] = mst_r_valid_i;
  end

  assign mst_r_ready_o = slv_r_ready_i[r_dst];

endmodule

// ==== read_xbar.sv ====
`timescale 1ns/1ns

module read_xbar (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  // Slave ports
  input  logic               [xbar_pkg::NO_SLV-1:0]     slv_ar_valid_i,
  input  xbar_pkg::slv_id_t  [xbar_pkg::NO_SLV-1:0]     slv_ar_id_i,
  input  xbar_pkg::addr_t    [xbar_pkg::NO_SLV-1:0]     slv_ar_addr_i,
  output logic               [xbar_pkg::NO_SLV-1:0]     slv_ar_ready_o,
  output logic               [xbar_pkg::NO_SLV-1:0]     slv_r_valid_o,
  output xbar_pkg::slv_id_t  [xbar_pkg::NO_SLV-1:0]     slv_r_id_o,
  output xbar_pkg::data_t    [xbar_pkg::NO_SLV-1:0]     slv_r_data_o,
  output xbar_pkg::resp_t    [xbar_pkg::NO_SLV-1:0]     slv_r_resp_o,
  input  logic               [xbar_pkg::NO_SLV-1:0]     slv_r_ready_i,
  // Master ports
  output logic               [xbar_pkg::NO_MST-1:0]     mst_ar_valid_o,
  output xbar_pkg::mst_id_t  [xbar_pkg::NO_MST-1:0]     mst_ar_id_o,
  output xbar_pkg::addr_t    [xbar_pkg::NO_MST-1:0]     mst_ar_addr_o,
  input  logic               [xbar_pkg::NO_MST-1:0]     mst_ar_ready_i,
  input  logic               [xbar_pkg::NO_MST-1:0]     mst_r_valid_i,
  input  xbar_pkg::mst_id_t  [xbar_pkg::NO_MST-1:0]     mst_r_id_i,
  input  xbar_pkg::data_t    [xbar_pkg::NO_MST-1:0]     mst_r_data_i,
  input  xbar_pkg::resp_t    [xbar_pkg::NO_MST-1:0]     mst_r_resp_i,
  output logic               [xbar_pkg::NO_MST-1:0]     mst_r_ready_o,
  // Address map, shared by all slave ports
  input  xbar_pkg::rule_t    [xbar_pkg::NO_RULES-1:0]   addr_map_i,
  input  logic               [xbar_pkg::NO_SLV-1:0]     en_default_i,
  input  xbar_pkg::mst_idx_t [xbar_pkg::NO_SLV-1:0]     default_port_i
);

  import xbar_pkg::*;

  // Demux side, indexed [slave][destination]
  ar_slv_t [NO_SLV-1:0]                dmx_ar;
  logic    [NO_SLV-1:0][NO_MST:0]      dmx_ar_valid;
  logic    [NO_SLV-1:0][NO_MST:0]      dmx_ar_ready;
  r_slv_t  [NO_SLV-1:0][NO_MST:0]      dmx_r;
  logic    [NO_SLV-1:0][NO_MST:0]      dmx_r_valid;
  logic    [NO_SLV-1:0][NO_MST:0]      dmx_r_ready;
  // Mux side, indexed [master][slave]
  ar_slv_t [NO_MST-1:0][NO_SLV-1:0]    mux_ar;
  logic    [NO_MST-1:0][NO_SLV-1:0]    mux_ar_valid;
  logic    [NO_MST-1:0][NO_SLV-1:0]    mux_ar_ready;
  r_slv_t  [NO_MST-1:0]                mux_r;
  logic    [NO_MST-1:0][NO_SLV-1:0]    mux_r_valid;
  logic    [NO_MST-1:0][NO_SLV-1:0]    mux_r_ready;

  for (genvar i = 0; i < NO_SLV; i++) begin : g_slv
    sel_t    ar_sel;
    ar_slv_t slv_ar;
    r_slv_t  slv_r;

    assign slv_ar.id   = slv_ar_id_i[i];
    assign slv_ar.addr = slv_ar_addr_i[i];

    addr_decode u_dec (
      .addr_i         ( slv_ar_addr_i[i]  ),
      .addr_map_i     ( addr_map_i        ),
      .en_default_i   ( en_default_i[i]   ),
      .default_port_i ( default_port_i[i] ),
      .sel_o          ( ar_sel            )
    );

    read_demux u_demux (
      .clk_i          ( clk_i             ),
      .rst_n_i        ( rst_n_i           ),
      .slv_ar_valid_i ( slv_ar_valid_i[i] ),
      .slv_ar_i       ( slv_ar            ),
      .slv_ar_ready_o ( slv_ar_ready_o[i] ),
      .sel_i          ( ar_sel            ),
      .slv_r_valid_o  ( slv_r_valid_o[i]  ),
      .slv_r_o        ( slv_r             ),
      .slv_r_ready_i  ( slv_r_ready_i[i]  ),
      .dst_ar_valid_o ( dmx_ar_valid[i]   ),
      .dst_ar_o       ( dmx_ar[i]         ),
      .dst_ar_ready_i ( dmx_ar_ready[i]   ),
      .dst_r_valid_i  ( dmx_r_valid[i]    ),
      .dst_r_i        ( dmx_r[i]          ),
      .dst_r_ready_o  ( dmx_r_ready[i]    )
    );

    assign slv_r_id_o[i]   = slv_r.id;
    assign slv_r_data_o[i] = slv_r.data;
    assign slv_r_resp_o[i] = slv_r.resp;

    // Last demux lane answers unmapped reads
    decerr_responder u_decerr (
      .clk_i      ( clk_i                     ),
      .rst_n_i    ( rst_n_i                   ),
      .ar_valid_i ( dmx_ar_valid[i][NO_MST]   ),
      .ar_i       ( dmx_ar[i]                 ),
      .ar_ready_o ( dmx_ar_ready[i][NO_MST]   ),
      .r_valid_o  ( dmx_r_valid[i][NO_MST]    ),
      .r_o        ( dmx_r[i][NO_MST]          ),
      .r_ready_i  ( dmx_r_ready[i][NO_MST]    )
    );

    // Swap [slave][master] into [master][slave]
    for (genvar j = 0; j < NO_MST; j++) begin : g_tp
      assign mux_ar_valid[j][i] = dmx_ar_valid[i][j];
      assign mux_ar[j][i]       = dmx_ar[i];
      assign dmx_ar_ready[i][j] = mux_ar_ready[j][i];
      assign dmx_r_valid[i][j]  = mux_r_valid[j][i];
      assign dmx_r[i][j]        = mux_r[j];
      assign mux_r_ready[j][i]  = dmx_r_ready[i][j];
    end
  end

  for (genvar j = 0; j < NO_MST; j++) begin : g_mst
    ar_mst_t mst_ar;
    r_mst_t  mst_r;

    assign mst_r.id   = mst_r_id_i[j];
    assign mst_r.data = mst_r_data_i[j];
    assign mst_r.resp = mst_r_resp_i[j];

    read_mux u_mux (
      .clk_i          ( clk_i             ),
      .rst_n_i        ( rst_n_i           ),
      .slv_ar_valid_i ( mux_ar_valid[j]   ),
      .slv_ar_i       ( mux_ar[j]         ),
      .slv_ar_ready_o ( mux_ar_ready[j]   ),
      .slv_r_valid_o  ( mux_r_valid[j]    ),
      .slv_r_o        ( mux_r[j]          ),
      .slv_r_ready_i  ( mux_r_ready[j]    ),
      .mst_ar_valid_o ( mst_ar_valid_o[j] ),
      .mst_ar_o       ( mst_ar            ),
      .mst_ar_ready_i ( mst_ar_ready_i[j] ),
      .mst_r_valid_i  ( mst_r_valid_i[j]  ),
      .mst_r_i        ( mst_r             ),
      .mst_r_ready_o  ( mst_r_ready_o[j]  )
    );

    assign mst_ar_id_o[j]   = mst_ar.id;
    assign mst_ar_addr_o[j] = mst_ar.addr;
  end

endmodule

// ==== read_xbar_assertions.sv ====
`timescale 1ns/1ns

module read_xbar_assertions (
  input logic                                       clk_i,
  input logic                                       rst_n_i,
  input logic              [xbar_pkg::NO_SLV-1:0]   slv_r_valid_o,
  input logic              [xbar_pkg::NO_SLV-1:0]   slv_r_ready_i,
  input xbar_pkg::slv_id_t [xbar_pkg::NO_SLV-1:0]   slv_r_id_o,
  input xbar_pkg::data_t   [xbar_pkg::NO_SLV-1:0]   slv_r_data_o,
  input logic              [xbar_pkg::NO_MST-1:0]   mst_ar_valid_o,
  input logic              [xbar_pkg::NO_MST-1:0]   mst_ar_ready_i,
  input xbar_pkg::mst_id_t [xbar_pkg::NO_MST-1:0]   mst_ar_id_o,
  input xbar_pkg::addr_t   [xbar_pkg::NO_MST-1:0]   mst_ar_addr_o
);

  import xbar_pkg::*;

  // Stalled R beat holds until taken
  for (genvar i = 0; i < NO_SLV; i++) begin : g_slv
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      slv_r_valid_o[i] && !slv_r_ready_i[i] |=> slv_r_valid_o[i] &&
      $stable(slv_r_id_o[i]) && $stable(slv_r_data_o[i]))
      else $error("slave R beat changed while stalled");
  end

  // Stalled master AR keeps grant and payload
  for (genvar j = 0; j < NO_MST; j++) begin : g_mst
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      mst_ar_valid_o[j] && !mst_ar_ready_i[j] |=> mst_ar_valid_o[j] &&
      $stable(mst_ar_id_o[j]) && $stable(mst_ar_addr_o[j]))
      else $error("master AR changed while stalled");
  end

  // Nothing valid in reset
  assert property (@(posedge clk_i) !rst_n_i |-> (slv_r_valid_o == '0) && (mst_ar_valid_o == '0))
    else $error("valid output high during reset");

endmodule

bind read_xbar read_xbar_assertions u_read_xbar_assertions (
  .clk_i          ( clk_i          ),
  .rst_n_i        ( rst_n_i        ),
  .slv_r_valid_o  ( slv_r_valid_o  ),
  .slv_r_ready_i  ( slv_r_ready_i  ),
  .slv_r_id_o     ( slv_r_id_o     ),
  .slv_r_data_o   ( slv_r_data_o   ),
  .mst_ar_valid_o ( mst_ar_valid_o ),
  .mst_ar_ready_i ( mst_ar_ready_i ),
  .mst_ar_id_o    ( mst_ar_id_o    ),
  .mst_ar_addr_o  ( mst_ar_addr_o  )
);

// ==== tb_read_xbar.sv ====
`timescale 1ns/1ns

module tb_read_xbar;

  import xbar_pkg::*;

  // Longest test takes a few hundred cycles, so this leaves plenty of margin
  localparam int unsigned TIMEOUT_CYC = 4000;

  logic clk_i = 1'b0;
  logic rst_n_i;

  logic     [NO_SLV-1:0]   slv_ar_valid_i;
  slv_id_t  [NO_SLV-1:0]   slv_ar_id_i;
  addr_t    [NO_SLV-1:0]   slv_ar_addr_i;
  logic     [NO_SLV-1:0]   slv_ar_ready_o;
  logic     [NO_SLV-1:0]   slv_r_valid_o;
  slv_id_t  [NO_SLV-1:0]   slv_r_id_o;
  data_t    [NO_SLV-1:0]   slv_r_data_o;
  resp_t    [NO_SLV-1:0]   slv_r_resp_o;
  logic     [NO_SLV-1:0]   slv_r_ready_i = '0;
  logic     [NO_MST-1:0]   mst_ar_valid_o;
  mst_id_t  [NO_MST-1:0]   mst_ar_id_o;
  addr_t    [NO_MST-1:0]   mst_ar_addr_o;
  logic     [NO_MST-1:0]   mst_ar_ready_i = '0;
  logic     [NO_MST-1:0]   mst_r_valid_i = '0;
  mst_id_t  [NO_MST-1:0]   mst_r_id_i = '0;
  data_t    [NO_MST-1:0]   mst_r_data_i = '0;
  resp_t    [NO_MST-1:0]   mst_r_resp_i = '0;
  logic     [NO_MST-1:0]   mst_r_ready_o;
  rule_t    [NO_RULES-1:0] addr_map_i;
  logic     [NO_SLV-1:0]   en_default_i;
  mst_idx_t [NO_SLV-1:0]   default_port_i;

  // Memory model state, one queue per master port
  ar_mst_t     pend_q [NO_MST][$];
  ar_mst_t     seen_q [NO_MST][$];
  int unsigned r_wait [NO_MST];
  logic [NO_MST-1:0] hold_r = '0;
  logic        ar_rand = 1'b0;
  logic        rdy_rand = 1'b0;
  // Collected R beats per slave port
  r_slv_t      got_q [NO_SLV][$];
  logic [NO_SLV-1:0] r_held = '0;
  r_slv_t      held_beat [NO_SLV];
  // Fairness tracking on master port 0
  logic        arb_chk = 1'b0;
  logic        have_last = 1'b0;
  logic        last_src;
  logic        other_waited;

  int unsigned mis_cnt = 0;
  int unsigned oth_cnt = 0;
  int unsigned cyc = 0;

  read_xbar u_read_xbar (.*);

  always #10 clk_i = ~clk_i;

  function automatic data_t model_data(int unsigned port, addr_t addr);
    return addr ^ (port * 32'h1000_0000);
  endfunction

  // Odd reads of a mixed stream move up by 0x1000 into master port 1's window
  function automatic addr_t stream_addr(addr_t base, int k, logic mix);
    if (mix && (k % 2 == 1)) begin
      return base + 4 * k + 32'h1000;
    end
    return base + 4 * k;
  endfunction

  task automatic report(string msg);
    oth_cnt++;
    $display("ERROR: %s", msg);
  endtask

  task automatic check_r(string name, r_slv_t got, r_slv_t exp);
    if (got.id !== exp.id) begin
      mis_cnt++;
      $display("MISMATCH %s.id got %h exp %h", name, got.id, exp.id);
    end
    if (got.data !== exp.data) begin
      mis_cnt++;
      $display("MISMATCH %s.data got %h exp %h", name, got.data, exp.data);
    end
    if (got.resp !== exp.resp) begin
      mis_cnt++;
      $display("MISMATCH %s.resp got %h exp %h", name, got.resp, exp.resp);
    end
  endtask

  task automatic check_mst_ar(string name, ar_mst_t got, ar_mst_t exp);
    if (got.id !== exp.id) begin
      mis_cnt++;
      $display("MISMATCH %s.id got %h exp %h", name, got.id, exp.id);
    end
    if (got.addr !== exp.addr) begin
      mis_cnt++;
      $display("MISMATCH %s.addr got %h exp %h", name, got.addr, exp.addr);
    end
  endtask

  // Run-length guard
  always @(posedge clk_i) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYC) begin
      $display("Timeout after %0d cycles, a read never completed", cyc);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // Master-port memory models, in-order with random R delay
  always @(posedge clk_i) begin
    ar_mst_t ar;
    if (rst_n_i) begin
      for (int j = 0; j < NO_MST; j++) begin
        if (mst_ar_valid_o[j] && mst_ar_ready_i[j]) begin
          ar.id   = mst_ar_id_o[j];
          ar.addr = mst_ar_addr_o[j];
          pend_q[j].push_back(ar);
          seen_q[j].push_back(ar);
          // Top ID bit is the source slave port
          if (j == 0 && arb_chk) begin
            if (have_last && last_src == ar.id[ID_W] && other_waited) begin
              report($sformatf("slave port %0d granted twice while the other waited",
                               ar.id[ID_W]));
            end
            have_last    = 1'b1;
            last_src     = ar.id[ID_W];
            other_waited = slv_ar_valid_i[!ar.id[ID_W]];
          end
        end
        mst_ar_ready_i[j] <= ar_rand ? (($urandom % 3) != 0) : 1'b1;
        if (mst_r_valid_i[j] && mst_r_ready_o[j]) begin
          void'(pend_q[j].pop_front());
          mst_r_valid_i[j] <= 1'b0;
          r_wait[j] = $urandom % 4;
        end else if (!mst_r_valid_i[j]) begin
          if (r_wait[j] > 0) begin
            r_wait[j]--;
          end else if (pend_q[j].size() > 0 && !hold_r[j]) begin
            mst_r_valid_i[j] <= 1'b1;
            mst_r_id_i[j]    <= pend_q[j][0].id;
            mst_r_data_i[j]  <= model_data(j, pend_q[j][0].addr);
            mst_r_resp_i[j]  <= RESP_OKAY;
          end
        end
      end
    end
  end

  // Slave-port R sinks, also watch that a stalled beat holds still
  always @(posedge clk_i) begin
    r_slv_t beat;
    if (rst_n_i) begin
      for (int p = 0; p < NO_SLV; p++) begin
        beat.id   = slv_r_id_o[p];
        beat.data = slv_r_data_o[p];
        beat.resp = slv_r_resp_o[p];
        if (r_held[p]) begin
          if (!slv_r_valid_o[p]) begin
            report($sformatf("R valid on slave port %0d dropped before the beat was taken", p));
          end else begin
            check_r("slv_r_stable", beat, held_beat[p]);
          end
        end
        if (slv_r_valid_o[p] && slv_r_ready_i[p]) begin
          got_q[p].push_back(beat);
        end
        r_held[p]    = slv_r_valid_o[p] && !slv_r_ready_i[p];
        held_beat[p] = beat;
        slv_r_ready_i[p] <= rdy_rand ? (($urandom % 2) != 0) : 1'b1;
      end
    end
  end

  // Issue one AR and wait for its handshake
  task automatic send_ar(int p, slv_id_t id, addr_t addr);
    @(posedge clk_i);
    slv_ar_valid_i[p] <= 1'b1;
    slv_ar_id_i[p]    <= id;
    slv_ar_addr_i[p]  <= addr;
    do begin
      @(posedge clk_i);
    end while (!slv_ar_ready_o[p]);
    slv_ar_valid_i[p] <= 1'b0;
  endtask

  task automatic wait_r(int p, slv_id_t id, data_t data, resp_t resp);
    r_slv_t exp;
    r_slv_t got;
    exp.id   = id;
    exp.data = data;
    exp.resp = resp;
    while (got_q[p].size() == 0) begin
      @(posedge clk_i);
    end
    got = got_q[p].pop_front();
    check_r($sformatf("slv_r[%0d]", p), got, exp);
  endtask

  task automatic expect_ar(int j, mst_id_t id, addr_t addr);
    ar_mst_t exp;
    exp.id   = id;
    exp.addr = addr;
    if (seen_q[j].size() == 0) begin
      report($sformatf("no AR seen at master port %0d for address %h", j, addr));
    end else begin
      check_mst_ar($sformatf("mst_ar[%0d]", j), seen_q[j].pop_front(), exp);
    end
  endtask

  task automatic clear_seen();
    for (int j = 0; j < NO_MST; j++) begin
      seen_q[j].delete();
    end
  endtask

  task automatic route_reads();
    clear_seen();
    send_ar(0, 4'h5, 32'h1004);
    wait_r(0, 4'h5, model_data(1, 32'h1004), RESP_OKAY);
    expect_ar(1, {1'b0, 4'h5}, 32'h1004);
    send_ar(1, 4'h5, 32'h1004);
    wait_r(1, 4'h5, model_data(1, 32'h1004), RESP_OKAY);
    expect_ar(1, {1'b1, 4'h5}, 32'h1004);
  endtask

  task automatic overlap_and_default();
    clear_seen();
    // Rule 2 overrides rule 0
    send_ar(0, 4'h3, 32'h0810);
    wait_r(0, 4'h3, model_data(1, 32'h0810), RESP_OKAY);
    expect_ar(1, {1'b0, 4'h3}, 32'h0810);
    send_ar(0, 4'h6, 32'h3000);
    wait_r(0, 4'h6, DECERR_DATA, RESP_DECERR);
    if (seen_q[0].size() + seen_q[1].size() != 0) begin
      report("unmapped read leaked to a master port");
    end
    @(posedge clk_i);
    en_default_i[0]   <= 1'b1;
    default_port_i[0] <= 1'b0;
    send_ar(0, 4'h7, 32'h3000);
    wait_r(0, 4'h7, model_data(0, 32'h3000), RESP_OKAY);
    expect_ar(0, {1'b0, 4'h7}, 32'h3000);
    en_default_i[0] <= 1'b0;
  endtask

  task automatic id_ordering();
    clear_seen();
    hold_r[0] <= 1'b1;
    send_ar(0, 4'h1, 32'h0010);
    // Another ID from the same slave port is not held back
    send_ar(0, 4'h2, 32'h1020);
    wait_r(0, 4'h2, model_data(1, 32'h1020), RESP_OKAY);
    expect_ar(1, {1'b0, 4'h2}, 32'h1020);
    fork
      send_ar(0, 4'h1, 32'h1010);
      begin
        repeat (10) @(posedge clk_i);
        // First ID 1 read still outstanding at port 0
        if (seen_q[1].size() != 0) begin
          report("second ID 1 read passed while the first was outstanding");
        end
        hold_r[0] <= 1'b0;
      end
    join
    wait_r(0, 4'h1, model_data(0, 32'h0010), RESP_OKAY);
    wait_r(0, 4'h1, model_data(1, 32'h1010), RESP_OKAY);
    expect_ar(0, {1'b0, 4'h1}, 32'h0010);
    expect_ar(1, {1'b0, 4'h1}, 32'h1010);
  endtask

  // AR valid stays high for the whole stream
  // Each read is driven on the handshake edge of the one before
  task automatic stream(int p, int n, addr_t base, logic mix);
    @(posedge clk_i);
    for (int k = 0; k < n; k++) begin
      slv_ar_valid_i[p] <= 1'b1;
      slv_ar_id_i[p]    <= slv_id_t'(k);
      slv_ar_addr_i[p]  <= stream_addr(base, k, mix);
      do begin
        @(posedge clk_i);
      end while (!slv_ar_ready_o[p]);
    end
    slv_ar_valid_i[p] <= 1'b0;
  endtask

  task automatic collect(int p, int n, addr_t base, int port);
    for (int k = 0; k < n; k++) begin
      wait_r(p, slv_id_t'(k), model_data(port, base + 4 * k), RESP_OKAY);
    end
  endtask

  // Beats of a mixed stream come back in any order and are matched by ID
  task automatic collect_mixed(int p, int n, addr_t base);
    r_slv_t             got;
    r_slv_t             exp;
    logic [2**ID_W-1:0] taken;
    taken = '0;
    for (int b = 0; b < n; b++) begin
      while (got_q[p].size() == 0) begin
        @(posedge clk_i);
      end
      got = got_q[p].pop_front();
      if (got.id >= n || taken[got.id]) begin
        report($sformatf("unexpected or repeated R beat with ID %h on slave port %0d",
                         got.id, p));
      end else begin
        taken[got.id] = 1'b1;
        exp.id   = got.id;
        exp.data = model_data(got.id % 2, stream_addr(base, got.id, 1'b1));
        exp.resp = RESP_OKAY;
        check_r($sformatf("slv_r[%0d]", p), got, exp);
      end
    end
  endtask

  task automatic arbitration_fairness();
    ar_rand   <= 1'b1;
    arb_chk   <= 1'b1;
    have_last = 1'b0;
    fork
      stream(0, 8, 32'h0100, 1'b0);
      stream(1, 8, 32'h0200, 1'b0);
    join
    collect(0, 8, 32'h0100, 0);
    collect(1, 8, 32'h0200, 0);
    arb_chk <= 1'b0;
    ar_rand <= 1'b0;
  endtask

  // Both master ports answer each slave port, so R beats compete while stalled
  task automatic r_backpressure();
    rdy_rand <= 1'b1;
    fork
      stream(0, 6, 32'h0300, 1'b1);
      stream(1, 6, 32'h0600, 1'b1);
    join
    collect_mixed(0, 6, 32'h0300);
    collect_mixed(1, 6, 32'h0600);
    rdy_rand <= 1'b0;
    repeat (5) @(posedge clk_i);
    if (got_q[0].size() + got_q[1].size() != 0) begin
      report("extra R beats arrived after the last read");
    end
  endtask

  initial begin
    void'($urandom(5992));
    rst_n_i        <= 1'b0;
    slv_ar_valid_i <= '0;
    slv_ar_id_i    <= '0;
    slv_ar_addr_i  <= '0;
    en_default_i   <= '0;
    default_port_i <= '0;
    addr_map_i[0]  = '{mst_idx: 1'b0, start_addr: 32'h0000, end_addr: 32'h1000};
    addr_map_i[1]  = '{mst_idx: 1'b1, start_addr: 32'h1000, end_addr: 32'h2000};
    addr_map_i[2]  = '{mst_idx: 1'b1, start_addr: 32'h0800, end_addr: 32'h0900};
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
    route_reads();
    overlap_and_default();
    id_ordering();
    arbitration_fairness();
    r_backpressure();
    repeat (5) @(posedge clk_i);
    $display("Errors: %0d mismatches, %0d other failures", mis_cnt, oth_cnt);
    if (mis_cnt + oth_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
xbar_pkg.sv
addr_decode.sv
rr_arbiter.sv
read_demux.sv
decerr_responder.sv
read_mux.sv
read_xbar.sv
read_xbar_assertions.sv
tb_read_xbar.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run with Verilator, verdict comes from the log
rm -f sim.log
{ verilator --binary --timing --assert -f vlog.f --top-module tb_read_xbar \
  && ./obj_dir/Vtb_read_xbar; } > sim.log 2>&1 \
  || echo "Simulation finished: FAIL" >> sim.log
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && exit 1
grep -q "Simulation finished: PASS" sim.log || exit 1
exit 0
